//--- audioPlaybackTop.f
common/ufiPkg.sv
common/audioPkg.sv
rtl/audioDma/audioDmaUnit.sv
rtl/ufiSram.sv
rtl/audioFifo.sv
rtl/pcmOut/pcmSerializer.sv
rtl/audioPlaybackTop.sv
test/tbClock.sv
test/audioPlaybackTb_chk.sv
test/audioPlaybackTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f audioPlaybackTop.f --top-module audioPlaybackTb -o simv \
	&& ./obj_dir/simv +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "Testbench passed" \
	&& echo "Simulation result: PASS" \
	|| { echo "Simulation result: FAIL"; exit 1; }

//--- test/audioPlaybackTb.sv
`timescale 1ns/1ps

module audioPlaybackTb;

	localparam int pDmaFifoDepth = 32;
	localparam int pFifoMargin = 4;
	localparam int pRamWords = 1024;
	localparam int pBclkDiv = 2;
	// iClk cycles per serial word
	localparam int lpWordClks = 16 * 2 * pBclkDiv;

	logic iClk;
	logic rstGen;
	logic rstReq;
	logic rst;
	logic hostWe;
	ufiPkg::memAdrs_t hostAdrs;
	audioPkg::sample_t hostData;
	logic dmaEn;
	ufiPkg::memAdrs_t dmaStart;
	ufiPkg::memAdrs_t dmaEnd;
	logic bclk;
	logic lrclk;
	logic sdata;
	logic underrun;

	// Expected RAM contents
	audioPkg::sample_t model [0:pRamWords-1];
	// Captured serial words and their lrclk tag
	audioPkg::sample_t capWords [$];
	logic capLr [$];
	audioPkg::sample_t shiftAcc;
	int bitPos;
	int errCnt;
	int testCnt;
	int failTests;

	// Startup reset or a test reset
	assign rst = rstGen | rstReq;

	tbClock clkGen (.iClk(iClk), .rst(rstGen));

	audioPlaybackTop #(
		.pDmaFifoDepth (pDmaFifoDepth),
		.pFifoMargin   (pFifoMargin),
		.pRamWords     (pRamWords),
		.pBclkDiv      (pBclkDiv)
	) dut (
		.iClk     (iClk),
		.rst      (rst),
		.hostWe   (hostWe),
		.hostAdrs (hostAdrs),
		.hostData (hostData),
		.dmaEn    (dmaEn),
		.dmaStart (dmaStart),
		.dmaEnd   (dmaEnd),
		.bclk     (bclk),
		.lrclk    (lrclk),
		.sdata    (sdata),
		.underrun (underrun)
	);

	// --------------------------------------------------
	// Serial capture
	// --------------------------------------------------

	// sdata and lrclk settle on the falling edge
	always @(posedge bclk)
	begin
		shiftAcc = {shiftAcc[14:0], sdata};
		bitPos = bitPos + 1;
		if (bitPos == 16)
		begin
			capWords.push_back(shiftAcc);
			capLr.push_back(lrclk);
			bitPos = 0;
		end
	end

	task automatic clearCapture();
		capWords.delete();
		capLr.delete();
		bitPos = 0;
		shiftAcc = '0;
	endtask

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------

	task automatic checkSample(input string name, input audioPkg::sample_t got,
		input audioPkg::sample_t exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			errCnt++;
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			errCnt++;
		end
	endtask

	task automatic noteFailure(input string what);
		$display("%s", what);
		errCnt++;
	endtask

	// Word value plus left/right position in the frame
	task automatic checkWord(input int idx, input audioPkg::sample_t exp);
		if (idx >= capWords.size())
			noteFailure($sformatf("Word %0d was never captured", idx));
		else
		begin
			checkSample($sformatf("word %0d", idx), capWords[idx], exp);
			checkFlag($sformatf("lrclk of word %0d", idx), capLr[idx], (idx % 2) == 1);
		end
	endtask

	task automatic finishTest(input string name, input int errStart);
		testCnt++;
		if (errCnt == errStart)
			$display("Test %0d %s: ok", testCnt, name);
		else
		begin
			failTests++;
			$display("Test %0d %s: %0d errors", testCnt, name, errCnt - errStart);
		end
	endtask

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------

	function automatic audioPkg::sample_t randSample();
		audioPkg::sample_t s;
		s = audioPkg::sample_t'($urandom() & 32'hffff);
		// Zero is the underrun word
		if (s == '0)
			s = 16'h0001;
		return s;
	endfunction

	task automatic applyReset();
		@(posedge iClk);
		dmaEn <= 1'b0;
		hostWe <= 1'b0;
		rstReq <= 1'b1;
		repeat (3) @(posedge iClk);
		rstReq <= 1'b0;
		clearCapture();
	endtask

	task automatic hostWrite(input ufiPkg::memAdrs_t adrs, input audioPkg::sample_t data);
		@(posedge iClk);
		hostWe <= 1'b1;
		hostAdrs <= adrs;
		hostData <= data;
		model[adrs] = data;
	endtask

	task automatic hostIdle();
		@(posedge iClk);
		hostWe <= 1'b0;
	endtask

	// Window set while disabled so the DMA parks on the start
	task automatic startPlay(input ufiPkg::memAdrs_t first, input ufiPkg::memAdrs_t last);
		@(posedge iClk);
		dmaStart <= first;
		dmaEnd <= last;
		@(posedge iClk);
		dmaEn <= 1'b1;
	endtask

	task automatic waitWords(input int target);
		int cycles;
		int limit;
		cycles = 0;
		limit = (target - capWords.size() + 2) * lpWordClks * 2;
		@(negedge iClk);
		while (capWords.size() < target && cycles < limit)
		begin
			@(negedge iClk);
			cycles++;
		end
		if (capWords.size() < target)
			noteFailure($sformatf("Timeout waiting for %0d captured words", target));
	endtask

	// First non-zero word from an index on, -1 if none
	function automatic int firstNonZero(input int from);
		for (int i = from; i < capWords.size(); i++)
			if (capWords[i] !== '0)
				return i;
		return -1;
	endfunction

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------

	task automatic testIdle();
		int errStart;
		errStart = errCnt;
		applyReset();
		repeat (40)
		begin
			@(negedge iClk);
			checkFlag("bclk", bclk, 1'b0);
			checkFlag("lrclk", lrclk, 1'b0);
			checkFlag("sdata", sdata, 1'b0);
			checkFlag("underrun", underrun, 1'b0);
		end
		finishTest("idle after reset", errStart);
	endtask

	task automatic testOrdered();
		int errStart;
		errStart = errCnt;
		applyReset();
		for (int a = 0; a < 64; a++)
			hostWrite(ufiPkg::memAdrs_t'(a), randSample());
		hostIdle();
		startPlay(19'd0, 19'd15);
		waitWords(16);
		for (int i = 0; i < 16; i++)
			checkWord(i, model[i]);
		checkFlag("underrun", underrun, 1'b0);
		finishTest("ordered playback", errStart);
	endtask

	task automatic testLoop();
		int errStart;
		errStart = errCnt;
		applyReset();
		startPlay(19'd20, 19'd25);
		waitWords(20);
		// Six-word window repeats
		for (int i = 0; i < 20; i++)
			checkWord(i, model[20 + (i % 6)]);
		checkFlag("underrun", underrun, 1'b0);
		finishTest("address loop", errStart);
	endtask

	task automatic testHostStall();
		int errStart;
		int cycles;
		int wrIdx;
		errStart = errCnt;
		applyReset();
		startPlay(19'd0, 19'd15);
		cycles = 0;
		wrIdx = 0;
		// Write bursts outside the window steal the RAM port
		while (capWords.size() < 24 && cycles < 40 * lpWordClks)
		begin
			repeat (4)
			begin
				hostWrite(ufiPkg::memAdrs_t'(512 + (wrIdx % 256)), randSample());
				wrIdx++;
			end
			hostIdle();
			repeat (3) @(posedge iClk);
			cycles += 8;
		end
		if (capWords.size() < 24)
			noteFailure("Timeout waiting for 24 captured words during host writes");
		for (int i = 0; i < 24; i++)
			checkWord(i, model[i % 16]);
		checkFlag("underrun", underrun, 1'b0);
		finishTest("host write stall", errStart);
	endtask

	task automatic testStopUnderrun();
		int errStart;
		int stopIdx;
		int cycles;
		int n;
		errStart = errCnt;
		applyReset();
		startPlay(19'd0, 19'd15);
		waitWords(4);
		@(posedge iClk);
		dmaEn <= 1'b0;
		stopIdx = capWords.size();
		cycles = 0;
		@(negedge iClk);
		while (!underrun && cycles < 60 * lpWordClks)
		begin
			@(negedge iClk);
			cycles++;
		end
		if (!underrun)
			noteFailure("Timeout waiting for underrun after dmaEn dropped");
		waitWords(capWords.size() + 3);
		// Buffered words in order, then only zeros
		n = 0;
		while (n < capWords.size() && capWords[n] === model[n % 16])
			n++;
		// FIFO was topped up to depth minus margin before the stop
		if (n < stopIdx + pDmaFifoDepth - pFifoMargin)
			noteFailure("Buffered words lost after dmaEn dropped");
		for (int i = n; i < capWords.size(); i++)
			checkWord(i, '0);
		checkFlag("underrun", underrun, 1'b1);
		finishTest("stop and underrun", errStart);
	endtask

	task automatic testRestart();
		int errStart;
		int markIdx;
		int firstIdx;
		int cycles;
		errStart = errCnt;
		// Serializer still sending zeros here
		startPlay(19'd30, 19'd37);
		markIdx = capWords.size();
		firstIdx = -1;
		cycles = 0;
		while ((firstIdx < 0 || capWords.size() < firstIdx + 10) && cycles < 40 * lpWordClks)
		begin
			@(negedge iClk);
			cycles++;
			firstIdx = firstNonZero(markIdx);
		end
		if (firstIdx < 0 || capWords.size() < firstIdx + 10)
			noteFailure("Timeout waiting for playback from the new start address");
		else
		begin
			for (int i = 0; i < 10; i++)
				checkWord(firstIdx + i, model[30 + (i % 8)]);
		end
		checkFlag("underrun", underrun, 1'b1);
		applyReset();
		@(negedge iClk);
		checkFlag("underrun", underrun, 1'b0);
		finishTest("restart", errStart);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial
	begin
		int cycles;
		rstReq = 1'b0;
		hostWe = 1'b0;
		hostAdrs = '0;
		hostData = '0;
		dmaEn = 1'b0;
		dmaStart = '0;
		dmaEnd = '0;
		errCnt = 0;
		testCnt = 0;
		failTests = 0;
		for (int a = 0; a < pRamWords; a++)
			model[a] = '0;
		clearCapture();
		void'($urandom(32'hdf3222b3));
		cycles = 0;
		while (rstGen && cycles < 20)
		begin
			@(posedge iClk);
			cycles++;
		end
		if (rstGen)
			noteFailure("Startup reset never released");
		testIdle();
		testOrdered();
		testLoop();
		testHostStall();
		testStopUnderrun();
		testRestart();
		errCnt += int'(dut.dma.dmaChk.failCnt + dut.fifo.fifoChk.failCnt);
		$display("Tests run: %0d, failed tests: %0d, errors: %0d", testCnt, failTests, errCnt);
		if (errCnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Whole-run limit
	initial
	begin
		#1000000;
		$display("Simulation watchdog expired before the tests finished");
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- test/audioPlaybackTb_chk.sv
`timescale 1ns/1ps

module audioPlaybackTb_chk #(
	// DMA rules when set, FIFO rule otherwise
	parameter bit pDmaSide = 1'b1
)(
	input logic             iClk,
	input logic             rst,
	// DMA command side
	input logic             cmd,
	input ufiPkg::ufiAdrs_t adrs,
	input ufiPkg::memAdrs_t adrsLo,
	input ufiPkg::memAdrs_t adrsHi,
	// FIFO write side
	input logic             push,
	input logic             full
);

	// Read back by the testbench at the end of the run
	int unsigned failCnt = 0;

	generate
		if (pDmaSide)
		begin : dmaRules
			// --------------------------------------------------
			// DMA rules
			// --------------------------------------------------

			// One idle bus cycle after every command
			cmdGap: assert property (@(posedge iClk) disable iff (rst) cmd |=> !cmd)
			else
			begin
				$error("ufiCmd high on two consecutive cycles");
				failCnt++;
			end

			// Reads stay inside the playback window
			adrsRange: assert property (@(posedge iClk) disable iff (rst)
				cmd |-> (adrs >= ufiPkg::ufiAdrs_t'(adrsLo) && adrs <= ufiPkg::ufiAdrs_t'(adrsHi)))
			else
			begin
				$error("ufiAdrs 0x%h outside 0x%h..0x%h", adrs, adrsLo, adrsHi);
				failCnt++;
			end
		end
		else
		begin : fifoRules
			// --------------------------------------------------
			// FIFO rule
			// --------------------------------------------------

			// Margin must absorb every in-flight read
			pushFull: assert property (@(posedge iClk) disable iff (rst) push |-> !full)
			else
			begin
				$error("push into a full FIFO");
				failCnt++;
			end
		end
	endgenerate

endmodule

// Same checker on both blocks, inputs of the other block tied off
bind audioDmaUnit audioPlaybackTb_chk #(.pDmaSide(1'b1)) dmaChk (
	.iClk   (iClk),
	.rst    (rst),
	.cmd    (ufiCmd),
	.adrs   (ufiAdrs),
	.adrsLo (dmaStart),
	.adrsHi (dmaEnd),
	.push   (1'b0),
	.full   (1'b0)
);

bind audioFifo audioPlaybackTb_chk #(.pDmaSide(1'b0)) fifoChk (
	.iClk   (iClk),
	.rst    (rst),
	.cmd    (1'b0),
	.adrs   ('0),
	.adrsLo ('0),
	.adrsHi ('0),
	.push   (push),
	.full   (full)
);

//--- test/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int pPeriod = 4,
	parameter int pRstCycles = 3
)(
	output logic iClk,
	output logic rst
);

	// Free running clock
	initial
	begin
		iClk = 1'b0;
		forever #(pPeriod / 2) iClk = ~iClk;
	end

	// Power-on reset, released on a rising edge
	initial
	begin
		rst = 1'b1;
		repeat (pRstCycles) @(posedge iClk);
		rst <= 1'b0;
	end

endmodule

//--- rtl/audioPlaybackTop.sv
`timescale 1ns/1ps

module audioPlaybackTop #(
	parameter int pDmaFifoDepth = 32,
	parameter int pFifoMargin = 4,
	parameter int pRamWords = 1024,
	parameter int pBclkDiv = 2
)(
	input  logic              iClk,
	input  logic              rst,
	// Host sample load
	input  logic              hostWe,
	input  ufiPkg::memAdrs_t  hostAdrs,
	input  audioPkg::sample_t hostData,
	// Playback window
	input  logic              dmaEn,
	input  ufiPkg::memAdrs_t  dmaStart,
	input  ufiPkg::memAdrs_t  dmaEnd,
	// Serial audio
	output logic              bclk,
	output logic              lrclk,
	output logic              sdata,
	output logic              underrun
);

	// --------------------------------------------------
	// UFI between DMA and RAM
	// --------------------------------------------------

	ufiPkg::ufiAdrs_t ufiAdrs;
	logic ufiCmd;
	logic ufiRdy;
	ufiPkg::ufiData_t ufiRd;
	logic ufiRdValid;

	// DMA to FIFO
	ufiPkg::ufiData_t dmaRd;
	logic dmaRdValid;
	logic fifoRoom;

	// FIFO to serializer
	logic pop;
	audioPkg::sample_t popData;
	logic empty;

	// Sample memory
	ufiSram #(
		.pRamWords  (pRamWords)
	) sram (
		.iClk       (iClk),
		.rst        (rst),
		.hostWe     (hostWe),
		.hostAdrs   (hostAdrs),
		.hostData   (hostData),
		.ufiAdrs    (ufiAdrs),
		.ufiCmd     (ufiCmd),
		.ufiRdy     (ufiRdy),
		.ufiRd      (ufiRd),
		.ufiRdValid (ufiRdValid)
	);

	// Read engine
	audioDmaUnit dma (
		.iClk       (iClk),
		.rst        (rst),
		.dmaEn      (dmaEn),
		.dmaStart   (dmaStart),
		.dmaEnd     (dmaEnd),
		.fifoRoom   (fifoRoom),
		.ufiRdy     (ufiRdy),
		.ufiRd      (ufiRd),
		.ufiRdValid (ufiRdValid),
		.ufiAdrs    (ufiAdrs),
		.ufiCmd     (ufiCmd),
		.dmaRd      (dmaRd),
		.dmaRdValid (dmaRdValid)
	);

	// Sample buffer
	audioFifo #(
		.pDmaFifoDepth (pDmaFifoDepth),
		.pFifoMargin   (pFifoMargin)
	) fifo (
		.iClk     (iClk),
		.rst      (rst),
		.push     (dmaRdValid),
		.pushData (dmaRd),
		.pop      (pop),
		.popData  (popData),
		.empty    (empty),
		.fifoRoom (fifoRoom)
	);

	// Serial output
	pcmSerializer #(
		.pBclkDiv (pBclkDiv)
	) pcm (
		.iClk     (iClk),
		.rst      (rst),
		.popData  (popData),
		.empty    (empty),
		.pop      (pop),
		.bclk     (bclk),
		.lrclk    (lrclk),
		.sdata    (sdata),
		.underrun (underrun)
	);

endmodule

//--- rtl/pcmOut/pcmSerializer.sv
`timescale 1ns/1ps

module pcmSerializer #(
	parameter int pBclkDiv = 2
)(
	input  logic              iClk,
	input  logic              rst,
	input  audioPkg::sample_t popData,
	input  logic              empty,
	output logic              pop,
	output logic              bclk,
	output logic              lrclk,
	output logic              sdata,
	output logic              underrun
);

	localparam int lpDivBits = $clog2(pBclkDiv + 1);
	localparam int lpMsb = audioPkg::pSampleWidth - 1;

	audioPkg::pcmState_t state;
	audioPkg::bitCnt_t bitCnt;
	audioPkg::bitCnt_t nextCnt;
	logic [lpDivBits-1:0] divCnt;
	logic divTc;
	logic fallTick;
	logic wordStart;
	// Popped word, zero on an empty FIFO
	audioPkg::sample_t popWord;
	// Next word waiting for its start
	audioPkg::sample_t holdWord;
	audioPkg::sample_t shiftReg;

	assign divTc = (divCnt == lpDivBits'(pBclkDiv - 1));
	// bclk about to fall, the only point sdata moves
	assign fallTick = divTc & bclk;
	assign nextCnt = bitCnt + 1'b1;
	// Low four bits wrap at each word boundary
	assign wordStart = (nextCnt[3:0] == 4'd0);
	assign popWord = empty ? '0 : popData;

	// --------------------------------------------------
	// Bit clock
	// --------------------------------------------------

	// Held low until the first sample is loaded
	always_ff @(posedge iClk)
	begin
		if (rst || state == audioPkg::idle)
		begin
			divCnt <= '0;
			bclk <= 1'b0;
		end
		else if (divTc)
		begin
			divCnt <= '0;
			bclk <= ~bclk;
		end
		else
			divCnt <= divCnt + 1'b1;
	end

	// --------------------------------------------------
	// Frame FSM
	// --------------------------------------------------

	always_ff @(posedge iClk)
	begin
		if (rst)
		begin
			state <= audioPkg::idle;
			bitCnt <= '0;
			pop <= 1'b0;
			lrclk <= 1'b0;
			sdata <= 1'b0;
		end
		else
		begin
			pop <= 1'b0;
			case (state)
				audioPkg::idle:
				begin
					// First word straight from the FIFO head
					if (pop)
					begin
						state <= audioPkg::left;
						bitCnt <= '0;
						lrclk <= 1'b0;
						sdata <= popWord[lpMsb];
					end
					else if (!empty)
						pop <= 1'b1;
				end
				default:
				begin
					if (fallTick)
					begin
						bitCnt <= nextCnt;
						if (wordStart)
						begin
							// Upper half of the frame is the right word
							lrclk <= nextCnt[4];
							state <= nextCnt[4] ? audioPkg::right : audioPkg::left;
							sdata <= holdWord[lpMsb];
						end
						else
							sdata <= shiftReg[lpMsb-1];
						// Fetch one bit ahead of the next word
						if (nextCnt[3:0] == 4'd15)
							pop <= 1'b1;
					end
				end
			endcase
		end
	end

	// --------------------------------------------------
	// Shift path
	// --------------------------------------------------

	always_ff @(posedge iClk)
	begin
		if (pop)
			holdWord <= popWord;
		if (state == audioPkg::idle && pop)
			shiftReg <= popWord;
		else if (state != audioPkg::idle && fallTick)
			shiftReg <= wordStart ? holdWord : {shiftReg[lpMsb-1:0], 1'b0};
	end

	// Sticky until reset
	always_ff @(posedge iClk)
	begin
		if (rst)
			underrun <= 1'b0;
		else if (pop && empty)
			underrun <= 1'b1;
	end

endmodule

//--- rtl/audioFifo.sv
`timescale 1ns/1ps

module audioFifo #(
	parameter int pDmaFifoDepth = 32,
	parameter int pFifoMargin = 4
)(
	input  logic              iClk,
	input  logic              rst,
	input  logic              push,
	input  audioPkg::sample_t pushData,
	input  logic              pop,
	output audioPkg::sample_t popData,
	output logic              empty,
	output logic              fifoRoom
);

	localparam int lpPtrBits = $clog2(pDmaFifoDepth);
	localparam int lpCntBits = $clog2(pDmaFifoDepth + 1);

	audioPkg::sample_t buffer [0:pDmaFifoDepth-1];

	logic [lpPtrBits-1:0] wrPtr;
	logic [lpPtrBits-1:0] rdPtr;
	logic [lpCntBits-1:0] fillCnt;
	logic [lpCntBits-1:0] freeCnt;
	logic full;
	logic doPush;
	logic doPop;

	// --------------------------------------------------
	// Status
	// --------------------------------------------------

	assign full = (fillCnt == lpCntBits'(pDmaFifoDepth));
	assign empty = (fillCnt == '0);
	assign doPush = push & ~full;
	assign doPop = pop & ~empty;

	// Keep margin slots for reads already on the bus
	assign freeCnt = lpCntBits'(pDmaFifoDepth) - fillCnt;
	assign fifoRoom = (freeCnt > lpCntBits'(pFifoMargin));

	// Head word, valid in the pop cycle
	assign popData = buffer[rdPtr];

	// --------------------------------------------------
	// Storage and pointers
	// --------------------------------------------------

	always_ff @(posedge iClk)
	begin
		if (doPush)
			buffer[wrPtr] <= pushData;
	end

	always_ff @(posedge iClk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			// Wrap also for non power of two depths
			if (doPush)
				wrPtr <= (wrPtr == lpPtrBits'(pDmaFifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == lpPtrBits'(pDmaFifoDepth - 1)) ? '0 : rdPtr + 1'b1;
		end
	end

	// Fill count
	always_ff @(posedge iClk)
	begin
		if (rst)
			fillCnt <= '0;
		else
		begin
			case ({doPush, doPop})
				2'b10: fillCnt <= fillCnt + 1'b1;
				2'b01: fillCnt <= fillCnt - 1'b1;
				default: fillCnt <= fillCnt;
			endcase
		end
	end

endmodule

//--- rtl/ufiSram.sv
`timescale 1ns/1ps

module ufiSram #(
	parameter int pRamWords = 1024
)(
	input  logic              iClk,
	input  logic              rst,
	// Host load port
	input  logic              hostWe,
	input  ufiPkg::memAdrs_t  hostAdrs,
	input  audioPkg::sample_t hostData,
	// UFI slave
	input  ufiPkg::ufiAdrs_t  ufiAdrs,
	input  logic              ufiCmd,
	output logic              ufiRdy,
	output ufiPkg::ufiData_t  ufiRd,
	output logic              ufiRdValid
);

	localparam int lpIdxBits = $clog2(pRamWords);

	ufiPkg::ufiData_t mem [0:pRamWords-1];

	// Host write, held one cycle before it takes the port
	logic wrPend;
	logic [lpIdxBits-1:0] wrIdx;
	audioPkg::sample_t wrData;

	// Read pipeline, stage one
	logic [lpIdxBits-1:0] rdIdx;
	ufiPkg::ufiData_t rdWord;
	logic rdVld;

	// Port busy next cycle, the DMA sees it one cycle ahead
	assign ufiRdy = ~hostWe;

	// Low bits only, memory is far smaller than the bus map
	assign rdIdx = ufiAdrs[lpIdxBits-1:0];

	// --------------------------------------------------
	// Host write capture
	// --------------------------------------------------

	always_ff @(posedge iClk)
	begin
		if (rst)
			wrPend <= 1'b0;
		else
			wrPend <= hostWe;
	end

	always_ff @(posedge iClk)
	begin
		wrIdx <= hostAdrs[lpIdxBits-1:0];
		wrData <= hostData;
	end

	// --------------------------------------------------
	// Single port
	// --------------------------------------------------

	// Write wins, never overlaps a command since ufiRdy was low before it
	always_ff @(posedge iClk)
	begin
		if (wrPend)
			mem[wrIdx] <= wrData;
		else if (ufiCmd)
			rdWord <= mem[rdIdx];
	end

	// Stage two, data out two cycles after the command
	always_ff @(posedge iClk)
	begin
		ufiRd <= rdWord;
	end

	always_ff @(posedge iClk)
	begin
		if (rst)
		begin
			rdVld <= 1'b0;
			ufiRdValid <= 1'b0;
		end
		else
		begin
			rdVld <= ufiCmd;
			ufiRdValid <= rdVld;
		end
	end

endmodule

//--- rtl/audioDma/audioDmaUnit.sv
`timescale 1ns/1ps

module audioDmaUnit
(
	input  logic              iClk,
	input  logic              rst,
	// Host control
	input  logic              dmaEn,
	input  ufiPkg::memAdrs_t  dmaStart,
	input  ufiPkg::memAdrs_t  dmaEnd,
	// Read enable from the FIFO
	input  logic              fifoRoom,
	// UFI read side
	input  logic              ufiRdy,
	input  ufiPkg::ufiData_t  ufiRd,
	input  logic              ufiRdValid,
	// UFI command side
	output ufiPkg::ufiAdrs_t  ufiAdrs,
	output logic              ufiCmd,
	// Toward the FIFO
	output ufiPkg::ufiData_t  dmaRd,
	output logic              dmaRdValid
);

	// Zero fill between memory and bus address
	localparam int lpAdrsPad = ufiPkg::pBusAdrsBit - ufiPkg::pMemAdrsWidth;

	// Next address to be read
	ufiPkg::memAdrs_t rdAdrs;
	// One-bit yield counter
	logic yieldCnt;
	logic yieldState;
	// Command accepted this cycle
	logic issue;
	logic adrsAtEnd;

	// --------------------------------------------------
	// Issue decision
	// --------------------------------------------------

	// Counter at its top value means the bus is given up
	assign yieldState = (yieldCnt == 1'b1);

	// All enables high and not yielding
	assign issue = dmaEn & fifoRoom & ufiRdy & ~yieldState;

	// Last word of the loop
	assign adrsAtEnd = (rdAdrs == dmaEnd);

	// Yield counter, bumps on every command and drops back after the idle cycle
	always_ff @(posedge iClk)
	begin
		if (rst)
			yieldCnt <= 1'b0;
		else if (!dmaEn || yieldState)
			yieldCnt <= 1'b0;
		else if (issue)
			yieldCnt <= yieldCnt + 1'b1;
	end

	// --------------------------------------------------
	// Address loop
	// --------------------------------------------------

	always_ff @(posedge iClk)
	begin
		// Disabled DMA parks on the start address
		if (rst || !dmaEn)
			rdAdrs <= dmaStart;
		else if (issue)
		begin
			// Wrap after the end address
			if (adrsAtEnd)
				rdAdrs <= dmaStart;
			else
				rdAdrs <= rdAdrs + 1'b1;
		end
	end

	// Bus address follows the issued command
	always_ff @(posedge iClk)
	begin
		if (issue)
			ufiAdrs <= {{lpAdrsPad{1'b0}}, rdAdrs};
	end

	// Read strobe, single cycle per command
	always_ff @(posedge iClk)
	begin
		if (rst)
			ufiCmd <= 1'b0;
		else
			ufiCmd <= issue;
	end

	// --------------------------------------------------
	// Return path
	// --------------------------------------------------

	// Data word, no reset
	always_ff @(posedge iClk)
	begin
		dmaRd <= ufiRd;
	end

	// Push strobe into the FIFO
	always_ff @(posedge iClk)
	begin
		if (rst)
			dmaRdValid <= 1'b0;
		else
			dmaRdValid <= ufiRdValid;
	end

endmodule

//--- common/audioPkg.sv
package audioPkg;

	// --------------------------------------------------
	// PCM frame format
	// --------------------------------------------------

	// 16-bit PCM only
	localparam int pSampleWidth = 16;

	// Left word plus right word
	localparam int pFrameBits = 32;

	typedef logic [pSampleWidth-1:0] sample_t;

	// Bit position inside one stereo frame
	typedef logic [$clog2(pFrameBits)-1:0] bitCnt_t;

	// Serializer FSM
	typedef enum logic [1:0] {idle, left, right} pcmState_t;

endpackage

//--- common/ufiPkg.sv
package ufiPkg;

	// --------------------------------------------------
	// UFI bus geometry
	// --------------------------------------------------

	// One data word per bus beat
	localparam int pUfiBusWidth = 16;

	// Full bus address, only the low memory bits are live
	localparam int pBusAdrsBit = 32;

	// Word address range of the on-chip memory map
	localparam int pMemAdrsWidth = 19;

	// --------------------------------------------------
	// Bus types
	// --------------------------------------------------

	typedef logic [pUfiBusWidth-1:0] ufiData_t;
	typedef logic [pBusAdrsBit-1:0] ufiAdrs_t;

	// Start, end and host addresses
	typedef logic [pMemAdrsWidth-1:0] memAdrs_t;

endpackage
